// ==== hw/acc_pkg.sv ====
package acc_pkg;

	////////////////////
	// Widths
	////////////////////

	// One accumulator or data byte
	typedef logic [7:0] data_t;
	// Instruction address
	typedef logic [7:0] addr_t;
	// Opcode in the high byte, operand in the low byte
	typedef logic [15:0] instr_t;

	// Instruction memory size in words
	localparam int ROM_DEPTH = 256;

	// Return stack depth and pointer width, pointer counts 0 to STACK_DEPTH
	localparam int STACK_DEPTH = 4;
	localparam int SP_W = $clog2(STACK_DEPTH + 1);
	localparam logic [SP_W-1:0] STACK_FULL = SP_W'(STACK_DEPTH);

	////////////////////
	// Encodings
	////////////////////

	// Unlisted codes run as NOP
	typedef enum logic [7:0] {
		OP_NOP  = 8'h00,
		OP_LDI  = 8'h01,
		OP_ADDI = 8'h02,
		OP_SUBI = 8'h03,
		OP_ANDI = 8'h04,
		OP_ORI  = 8'h05,
		OP_XORI = 8'h06,
		OP_SHL  = 8'h07,
		OP_SHR  = 8'h08,
		OP_JMP  = 8'h09,
		OP_JZ   = 8'h0a,
		OP_JC   = 8'h0b,
		OP_CALL = 8'h0c,
		OP_RET  = 8'h0d,
		OP_IN   = 8'h0e,
		OP_OUT  = 8'h0f,
		OP_HALT = 8'h10
	} opcode_t;

	// ALU function select
	typedef enum logic [2:0] {
		ALU_PASS = 3'd0,
		ALU_ADD  = 3'd1,
		ALU_SUB  = 3'd2,
		ALU_AND  = 3'd3,
		ALU_OR   = 3'd4,
		ALU_XOR  = 3'd5,
		ALU_SHL  = 3'd6,
		ALU_SHR  = 3'd7
	} alu_op_t;

	// Low two bits are the plain PC moves, top bit marks return
	typedef enum logic [2:0] {
		PC_HOLD = 3'b000,
		PC_INC  = 3'b001,
		PC_JUMP = 3'b010,
		PC_CALL = 3'b011,
		PC_RET  = 3'b100
	} pc_op_t;

	// Controller states
	typedef enum logic [2:0] {
		ST_IDLE     = 3'd0,
		ST_FETCH    = 3'd1,
		ST_EXEC     = 3'd2,
		ST_IN_WAIT  = 3'd3,
		ST_OUT_WAIT = 3'd4,
		ST_HALTED   = 3'd5
	} ctrl_state_t;

endpackage

// ==== hw/acc_ifs.sv ====
`timescale 1ns/1ns

// Controller to ALU
interface alu_ctrl_if;
	// Driven by control
	acc_pkg::alu_op_t alu_op;
	logic alu_load;
	logic use_input;
	acc_pkg::data_t operand;
	// Driven by the ALU
	acc_pkg::data_t acc;
	logic zero;
	logic carry;

	modport ctrl (output alu_op, alu_load, use_input, operand, input acc, zero, carry);
	modport alu (input alu_op, alu_load, use_input, operand, output acc, zero, carry);
endinterface

// Controller to program counter
interface pc_ctrl_if;
	// Driven by control
	acc_pkg::pc_op_t pc_op;
	acc_pkg::addr_t target;
	// Driven by the PC unit
	acc_pkg::addr_t pc;
	logic stack_fault;

	modport ctrl (output pc_op, target, input pc, stack_fault);
	modport pcu (input pc_op, target, output pc, stack_fault);
endinterface

// ==== hw/acc_control.sv ====
`timescale 1ns/1ns

module acc_control (
	input logic clk,
	input logic rst,
	input logic run,
	input logic in_ready,
	input logic out_done,
	input acc_pkg::instr_t rom_word,
	output logic in_take,
	output logic out_start,
	output logic halted,
	alu_ctrl_if.ctrl alu,
	pc_ctrl_if.ctrl pcu
);

	acc_pkg::ctrl_state_t state;
	acc_pkg::ctrl_state_t state_next;
	acc_pkg::opcode_t opcode;
	acc_pkg::data_t operand;

	// Split of the registered ROM word
	assign opcode = acc_pkg::opcode_t'(rom_word[15:8]);
	assign operand = rom_word[7:0];

	// Immediate goes to the ALU and to the PC target
	assign alu.operand = operand;
	assign pcu.target = operand;

	// Sticky until reset
	assign halted = (state == acc_pkg::ST_HALTED);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= acc_pkg::ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	////////////////////
	// Next state and decode
	////////////////////

	always_comb begin
		state_next = state;
		alu.alu_op = acc_pkg::ALU_PASS;
		alu.alu_load = 1'b0;
		alu.use_input = 1'b0;
		pcu.pc_op = acc_pkg::PC_HOLD;
		in_take = 1'b0;
		out_start = 1'b0;

		case (state)
			acc_pkg::ST_IDLE: begin
				if (run) begin
					state_next = acc_pkg::ST_FETCH;
				end
			end

			// ROM registers mem[pc] on this edge
			acc_pkg::ST_FETCH: begin
				if (pcu.stack_fault) begin
					state_next = acc_pkg::ST_HALTED;
				end else if (!run) begin
					state_next = acc_pkg::ST_IDLE;
				end else begin
					state_next = acc_pkg::ST_EXEC;
				end
			end

			acc_pkg::ST_EXEC: begin
				state_next = acc_pkg::ST_FETCH;
				pcu.pc_op = acc_pkg::PC_INC;
				case (opcode)
					acc_pkg::OP_LDI: begin
						alu.alu_op = acc_pkg::ALU_PASS;
						alu.alu_load = 1'b1;
					end
					acc_pkg::OP_ADDI: begin
						alu.alu_op = acc_pkg::ALU_ADD;
						alu.alu_load = 1'b1;
					end
					acc_pkg::OP_SUBI: begin
						alu.alu_op = acc_pkg::ALU_SUB;
						alu.alu_load = 1'b1;
					end
					acc_pkg::OP_ANDI: begin
						alu.alu_op = acc_pkg::ALU_AND;
						alu.alu_load = 1'b1;
					end
					acc_pkg::OP_ORI: begin
						alu.alu_op = acc_pkg::ALU_OR;
						alu.alu_load = 1'b1;
					end
					acc_pkg::OP_XORI: begin
						alu.alu_op = acc_pkg::ALU_XOR;
						alu.alu_load = 1'b1;
					end
					acc_pkg::OP_SHL: begin
						alu.alu_op = acc_pkg::ALU_SHL;
						alu.alu_load = 1'b1;
					end
					acc_pkg::OP_SHR: begin
						alu.alu_op = acc_pkg::ALU_SHR;
						alu.alu_load = 1'b1;
					end
					acc_pkg::OP_JMP: pcu.pc_op = acc_pkg::PC_JUMP;
					// Branches resolve from the current flags
					acc_pkg::OP_JZ: pcu.pc_op = alu.zero ? acc_pkg::PC_JUMP : acc_pkg::PC_INC;
					acc_pkg::OP_JC: pcu.pc_op = alu.carry ? acc_pkg::PC_JUMP : acc_pkg::PC_INC;
					acc_pkg::OP_CALL: pcu.pc_op = acc_pkg::PC_CALL;
					acc_pkg::OP_RET: pcu.pc_op = acc_pkg::PC_RET;
					// PC held until the device side finishes
					acc_pkg::OP_IN: begin
						pcu.pc_op = acc_pkg::PC_HOLD;
						state_next = acc_pkg::ST_IN_WAIT;
					end
					acc_pkg::OP_OUT: begin
						pcu.pc_op = acc_pkg::PC_HOLD;
						out_start = 1'b1;
						state_next = acc_pkg::ST_OUT_WAIT;
					end
					acc_pkg::OP_HALT: begin
						pcu.pc_op = acc_pkg::PC_HOLD;
						state_next = acc_pkg::ST_HALTED;
					end
					default: begin
					end
				endcase
			end

			// Latched byte straight into the accumulator
			acc_pkg::ST_IN_WAIT: begin
				if (in_ready) begin
					in_take = 1'b1;
					alu.alu_op = acc_pkg::ALU_PASS;
					alu.alu_load = 1'b1;
					alu.use_input = 1'b1;
					pcu.pc_op = acc_pkg::PC_INC;
					state_next = acc_pkg::ST_FETCH;
				end
			end

			// out_done coincides with the fall of out_dev_req
			acc_pkg::ST_OUT_WAIT: begin
				if (out_done) begin
					pcu.pc_op = acc_pkg::PC_INC;
					state_next = acc_pkg::ST_FETCH;
				end
			end

			acc_pkg::ST_HALTED: state_next = acc_pkg::ST_HALTED;

			default: state_next = acc_pkg::ST_IDLE;
		endcase
	end

endmodule

// ==== hw/acc_alu.sv ====
`timescale 1ns/1ns

module acc_alu (
	input logic clk,
	input logic rst,
	input acc_pkg::data_t in_data,
	alu_ctrl_if.alu alu
);

	acc_pkg::data_t src;
	// Bit 8 is carry, or borrow for SUB
	logic [8:0] result;

	// Operand or the latched input byte
	assign src = alu.use_input ? in_data : alu.operand;

	always_comb begin
		case (alu.alu_op)
			acc_pkg::ALU_PASS: result = {1'b0, src};
			acc_pkg::ALU_ADD: result = {1'b0, alu.acc} + {1'b0, src};
			acc_pkg::ALU_SUB: result = {1'b0, alu.acc} - {1'b0, src};
			acc_pkg::ALU_AND: result = {1'b0, alu.acc & src};
			acc_pkg::ALU_OR: result = {1'b0, alu.acc | src};
			acc_pkg::ALU_XOR: result = {1'b0, alu.acc ^ src};
			// Bit shifted out lands in carry
			acc_pkg::ALU_SHL: result = {alu.acc[7], alu.acc[6:0], 1'b0};
			acc_pkg::ALU_SHR: result = {alu.acc[0], 1'b0, alu.acc[7:1]};
			default: result = {1'b0, alu.acc};
		endcase
	end

	// Accumulator and flags
	always_ff @(posedge clk) begin
		if (rst) begin
			alu.acc <= '0;
			alu.zero <= 1'b0;
			alu.carry <= 1'b0;
		end else if (alu.alu_load) begin
			alu.acc <= result[7:0];
			alu.zero <= (result[7:0] == '0);
			alu.carry <= result[8];
		end
	end

endmodule

// ==== hw/pc_unit.sv ====
`timescale 1ns/1ns

module pc_unit (
	input logic clk,
	input logic rst,
	pc_ctrl_if.pcu pcu
);

	// Return addresses
	acc_pkg::addr_t stack_mem [acc_pkg::STACK_DEPTH];
	// Number of entries in use
	logic [acc_pkg::SP_W-1:0] sp;
	logic [acc_pkg::SP_W-1:0] sp_dec;
	acc_pkg::addr_t pc_plus1;

	assign pc_plus1 = pcu.pc + 8'd1;
	assign sp_dec = sp - 1'b1;

	////////////////////
	// PC and pointer
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			pcu.pc <= '0;
			sp <= '0;
			pcu.stack_fault <= 1'b0;
		end else begin
			case (pcu.pc_op)
				acc_pkg::PC_INC: pcu.pc <= pc_plus1;
				acc_pkg::PC_JUMP: pcu.pc <= pcu.target;
				acc_pkg::PC_CALL: begin
					// Overflow holds the PC and flags the fault
					if (sp == acc_pkg::STACK_FULL) begin
						pcu.stack_fault <= 1'b1;
					end else begin
						sp <= sp + 1'b1;
						pcu.pc <= pcu.target;
					end
				end
				acc_pkg::PC_RET: begin
					// Underflow on empty stack
					if (sp == '0) begin
						pcu.stack_fault <= 1'b1;
					end else begin
						sp <= sp_dec;
						pcu.pc <= stack_mem[sp_dec[acc_pkg::SP_W-2:0]];
					end
				end
				default: begin
				end
			endcase
		end
	end

	// Stack storage
	always_ff @(posedge clk) begin
		if (pcu.pc_op == acc_pkg::PC_CALL && sp != acc_pkg::STACK_FULL) begin
			stack_mem[sp[acc_pkg::SP_W-2:0]] <= pc_plus1;
		end
	end

endmodule

// ==== hw/instr_rom.sv ====
`timescale 1ns/1ns

module instr_rom (
	input logic clk,
	input logic we,
	input acc_pkg::addr_t waddr,
	input acc_pkg::addr_t raddr,
	input acc_pkg::instr_t wdata,
	output acc_pkg::instr_t rdata
);

	// Program store, loaded from outside
	acc_pkg::instr_t mem [acc_pkg::ROM_DEPTH];

	////////////////////
	// Write port
	////////////////////

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	////////////////////
	// Read port
	////////////////////

	// Registered every cycle, old data on a same-address write
	// Word stays put while the PC holds
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

// ==== hw/io_port.sv ====
`timescale 1ns/1ns

module io_port (
	input logic clk,
	input logic rst,
	input logic in_dev_hs,
	input acc_pkg::data_t input_bus,
	input logic in_take,
	output logic in_ready,
	output acc_pkg::data_t in_data,
	output logic in_dev_ack,
	input logic out_dev_hs,
	input logic out_dev_ack,
	input logic out_start,
	input acc_pkg::data_t out_value,
	output logic out_done,
	output logic out_dev_req,
	output acc_pkg::data_t output_bus
);

	// Byte latched and not yet taken
	logic in_full;
	// Device still holding in_dev_hs for the byte already latched
	logic in_hold;
	// OUT issued, waiting for the device to be ready
	logic out_pend;
	acc_pkg::data_t out_reg;

	////////////////////
	// Input side
	////////////////////

	assign in_ready = in_full;

	always_ff @(posedge clk) begin
		if (rst) begin
			in_full <= 1'b0;
			in_hold <= 1'b0;
			in_dev_ack <= 1'b0;
		end else begin
			// One-cycle ack after the controller takes the byte
			in_dev_ack <= in_take;
			if (in_take) begin
				in_full <= 1'b0;
			end else if (in_dev_hs && !in_hold && !in_full) begin
				in_full <= 1'b1;
				in_hold <= 1'b1;
			end
			// Re-arm once the device drops its handshake
			if (!in_dev_hs) begin
				in_hold <= 1'b0;
			end
		end
	end

	// Data byte capture
	always_ff @(posedge clk) begin
		if (in_dev_hs && !in_hold && !in_full) begin
			in_data <= input_bus;
		end
	end

	////////////////////
	// Output side
	////////////////////

	assign output_bus = out_reg;
	// Request falls on the edge where the ack is seen
	assign out_done = out_dev_req && out_dev_ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			out_pend <= 1'b0;
			out_dev_req <= 1'b0;
		end else if (out_start) begin
			out_pend <= 1'b1;
		end else if (out_pend && !out_dev_req && out_dev_hs) begin
			out_dev_req <= 1'b1;
		end else if (out_done) begin
			out_dev_req <= 1'b0;
			out_pend <= 1'b0;
		end
	end

	// Loaded only while no request is up
	always_ff @(posedge clk) begin
		if (out_start) begin
			out_reg <= out_value;
		end
	end

endmodule

// ==== hw/acc_processor.sv ====
`timescale 1ns/1ns

module acc_processor (
	input logic clk,
	input logic rst,
	input logic run,
	input logic prog_we,
	input acc_pkg::addr_t prog_addr,
	input acc_pkg::instr_t prog_data,
	input logic in_dev_hs,
	input acc_pkg::data_t input_bus,
	output logic in_dev_ack,
	input logic out_dev_hs,
	input logic out_dev_ack,
	output logic out_dev_req,
	output acc_pkg::data_t output_bus,
	output logic halted
);

	// Fetched instruction word
	acc_pkg::instr_t rom_word;
	// Controller to I/O port
	logic in_take;
	logic out_start;
	logic in_ready;
	logic out_done;
	// Latched input byte for the ALU
	acc_pkg::data_t in_data;

	alu_ctrl_if alu_if ();
	pc_ctrl_if pc_if ();

	////////////////////
	// Control
	////////////////////

	acc_control u_acc_control (
		.clk(clk),
		.rst(rst),
		.run(run),
		.in_ready(in_ready),
		.out_done(out_done),
		.rom_word(rom_word),
		.in_take(in_take),
		.out_start(out_start),
		.halted(halted),
		.alu(alu_if.ctrl),
		.pcu(pc_if.ctrl)
	);

	////////////////////
	// Datapath
	////////////////////

	acc_alu u_acc_alu (
		.clk(clk),
		.rst(rst),
		.in_data(in_data),
		.alu(alu_if.alu)
	);

	pc_unit u_pc_unit (
		.clk(clk),
		.rst(rst),
		.pcu(pc_if.pcu)
	);

	// Read address follows the PC
	instr_rom u_instr_rom (
		.clk(clk),
		.we(prog_we),
		.waddr(prog_addr),
		.raddr(pc_if.pc),
		.wdata(prog_data),
		.rdata(rom_word)
	);

	// Output byte comes from the accumulator
	io_port u_io_port (
		.clk(clk),
		.rst(rst),
		.in_dev_hs(in_dev_hs),
		.input_bus(input_bus),
		.in_take(in_take),
		.in_ready(in_ready),
		.in_data(in_data),
		.in_dev_ack(in_dev_ack),
		.out_dev_hs(out_dev_hs),
		.out_dev_ack(out_dev_ack),
		.out_start(out_start),
		.out_value(alu_if.acc),
		.out_done(out_done),
		.out_dev_req(out_dev_req),
		.output_bus(output_bus)
	);

endmodule

// ==== bench/acc_processor_props.sv ====
`timescale 1ns/1ns

module acc_processor_props (
	input logic clk,
	input logic rst,
	input logic in_dev_ack,
	input logic out_dev_req,
	input logic out_dev_ack,
	input acc_pkg::data_t output_bus
);

	// Failed property count, read by the testbench at the end
	int fail_count = 0;

	////////////////////
	// Input side
	////////////////////

	// Single-cycle acknowledge per latched byte
	ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
		in_dev_ack |=> !in_dev_ack)
		else begin
			fail_count++;
			$error("in_dev_ack stayed high for more than one cycle");
		end

	////////////////////
	// Output side
	////////////////////

	// Request held until the device acknowledges
	req_until_ack: assert property (@(posedge clk) disable iff (rst)
		out_dev_req && !out_dev_ack |=> out_dev_req)
		else begin
			fail_count++;
			$error("out_dev_req fell before out_dev_ack was seen");
		end

	// Byte frozen while requested
	bus_stable: assert property (@(posedge clk) disable iff (rst)
		out_dev_req |=> $stable(output_bus))
		else begin
			fail_count++;
			$error("output_bus changed while out_dev_req was high");
		end

endmodule

bind io_port acc_processor_props u_props (
	.clk(clk),
	.rst(rst),
	.in_dev_ack(in_dev_ack),
	.out_dev_req(out_dev_req),
	.out_dev_ack(out_dev_ack),
	.output_bus(output_bus)
);

// ==== bench/acc_processor_tb.sv ====
`timescale 1ns/1ns

module acc_processor_tb;

	// Worst case near 1500 cycles including memory fill and 5-cycle stalls
	localparam int MAX_CYCLES = 4000;
	// Wait bound for halted in a single test that needs 250 cycles at most
	localparam int RUN_LIMIT = 400;
	// Interpreter gives up here
	localparam int REF_STEP_LIMIT = 2000;

	logic clk;
	logic rst;
	logic run;
	logic prog_we;
	acc_pkg::addr_t prog_addr;
	acc_pkg::instr_t prog_data;
	logic in_dev_hs;
	acc_pkg::data_t input_bus;
	logic in_dev_ack;
	logic out_dev_hs;
	logic out_dev_ack;
	logic out_dev_req;
	acc_pkg::data_t output_bus;
	logic halted;

	// Mirror of the DUT program memory
	acc_pkg::instr_t prog_mem [256];
	int prog_len;
	// Input device bytes and expected output stream
	acc_pkg::data_t in_bytes [$];
	acc_pkg::data_t exp_out [$];
	int in_next;
	int out_count;
	int ack_count;
	int errors;
	int checks;
	int cycles;
	int seed = 32'haf2d;
	string test_name;

	acc_processor u_acc_processor (
		.clk(clk),
		.rst(rst),
		.run(run),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.in_dev_hs(in_dev_hs),
		.input_bus(input_bus),
		.in_dev_ack(in_dev_ack),
		.out_dev_hs(out_dev_hs),
		.out_dev_ack(out_dev_ack),
		.out_dev_req(out_dev_req),
		.output_bus(output_bus),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////
	// Helpers
	////////////////////

	function automatic acc_pkg::data_t rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// 0 to 5 cycles
	function automatic int rand_delay();
		logic [31:0] r;
		r = $random(seed);
		return int'(r % 6);
	endfunction

	task automatic check_value(input string what, input int expected, input int actual);
		checks++;
		assert (expected == actual) else begin
			errors++;
			$display("FAIL %s %s: expected %0h actual %0h", test_name, what, expected, actual);
		end
	endtask

	task automatic finish_run();
		int prop_fails;
		prop_fails = u_acc_processor.u_io_port.u_props.fail_count;
		$display("Checks: %0d  errors: %0d  assertion failures: %0d",
			checks, errors, prop_fails);
		if (errors == 0 && prop_fails == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	endtask

	// Interpreter over prog_mem that fills exp_out and returns 1 on halt or stack fault
	function automatic bit ref_run();
		acc_pkg::data_t acc;
		acc_pkg::data_t arg;
		acc_pkg::addr_t pc;
		acc_pkg::addr_t next_pc;
		acc_pkg::addr_t stack [acc_pkg::STACK_DEPTH];
		bit zf;
		bit cf;
		bit loads;
		int sp;
		int in_idx;
		int steps;
		exp_out.delete();
		acc = '0;
		pc = '0;
		zf = 1'b0;
		cf = 1'b0;
		sp = 0;
		in_idx = 0;
		for (steps = 0; steps < REF_STEP_LIMIT; steps++) begin
			arg = prog_mem[pc][7:0];
			next_pc = pc + 8'd1;
			loads = 1'b1;
			case (prog_mem[pc][15:8])
				acc_pkg::OP_LDI: begin
					acc = arg;
					cf = 1'b0;
				end
				acc_pkg::OP_ADDI: begin
					cf = (int'(acc) + int'(arg)) > 255;
					acc = acc + arg;
				end
				// Borrow when the operand is larger
				acc_pkg::OP_SUBI: begin
					cf = arg > acc;
					acc = acc - arg;
				end
				acc_pkg::OP_ANDI: begin
					acc = acc & arg;
					cf = 1'b0;
				end
				acc_pkg::OP_ORI: begin
					acc = acc | arg;
					cf = 1'b0;
				end
				acc_pkg::OP_XORI: begin
					acc = acc ^ arg;
					cf = 1'b0;
				end
				acc_pkg::OP_SHL: begin
					cf = acc[7];
					acc = acc << 1;
				end
				acc_pkg::OP_SHR: begin
					cf = acc[0];
					acc = acc >> 1;
				end
				acc_pkg::OP_IN: begin
					if (in_idx >= in_bytes.size()) begin
						return 1'b0;
					end
					acc = in_bytes[in_idx];
					in_idx++;
					cf = 1'b0;
				end
				default: loads = 1'b0;
			endcase
			if (loads) begin
				zf = (acc == 8'd0);
			end
			case (prog_mem[pc][15:8])
				acc_pkg::OP_JMP: next_pc = arg;
				acc_pkg::OP_JZ: next_pc = zf ? arg : next_pc;
				acc_pkg::OP_JC: next_pc = cf ? arg : next_pc;
				// Overflow and underflow both stop the machine
				acc_pkg::OP_CALL: begin
					if (sp == acc_pkg::STACK_DEPTH) begin
						return 1'b1;
					end
					stack[sp] = next_pc;
					sp++;
					next_pc = arg;
				end
				acc_pkg::OP_RET: begin
					if (sp == 0) begin
						return 1'b1;
					end
					sp--;
					next_pc = stack[sp];
				end
				acc_pkg::OP_OUT: exp_out.push_back(acc);
				acc_pkg::OP_HALT: return 1'b1;
				default: begin
				end
			endcase
			pc = next_pc;
		end
		return 1'b0;
	endfunction

	task automatic emit(input acc_pkg::opcode_t op, input int arg);
		prog_mem[prog_len] = {op, 8'(arg)};
		prog_len++;
	endtask

	task automatic write_word(input acc_pkg::addr_t addr, input acc_pkg::instr_t word);
		prog_we = 1'b1;
		prog_addr = addr;
		prog_data = word;
		@(negedge clk);
		prog_we = 1'b0;
	endtask

	// Reset, load, run until halted
	task automatic run_test(input string name);
		bit exp_halt;
		int a;
		int waited;
		test_name = name;
		exp_halt = ref_run();
		rst = 1'b1;
		run = 1'b0;
		in_next = 0;
		out_count = 0;
		ack_count = 0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		for (a = 0; a < prog_len; a++) begin
			write_word(8'(a), prog_mem[a]);
		end
		run = 1'b1;
		waited = 0;
		while (!halted && waited < RUN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		run = 1'b0;
		check_value("output count", exp_out.size(), out_count);
		check_value("halted", int'(exp_halt), int'(halted));
	endtask

	////////////////////
	// Device models
	////////////////////

	// Input device gives one byte per handshake
	always begin : input_device
		int delay;
		@(negedge clk);
		if (!rst && in_next < in_bytes.size()) begin
			delay = rand_delay();
			repeat (delay) @(negedge clk);
			input_bus = in_bytes[in_next];
			in_dev_hs = 1'b1;
			@(negedge clk);
			while (!in_dev_ack) @(negedge clk);
			in_dev_hs = 1'b0;
			in_next++;
		end
	end

	// Output device is always ready and acks after a random stall
	always begin : output_device
		int delay;
		@(negedge clk);
		if (out_dev_req && !out_dev_ack) begin
			delay = rand_delay();
			repeat (delay) @(negedge clk);
			out_dev_ack = 1'b1;
			while (out_dev_req) @(negedge clk);
			out_dev_ack = 1'b0;
		end
	end

	////////////////////
	// Checkers
	////////////////////

	// Byte accepted on the edge with req and ack both high
	always @(posedge clk) begin
		if (!rst && out_dev_req && out_dev_ack) begin
			assert (out_count < exp_out.size()) else begin
				errors++;
				$display("%s: DUT sent output byte %0d but only %0d were expected",
					test_name, out_count, exp_out.size());
			end
			if (out_count < exp_out.size()) begin
				check_value($sformatf("output byte %0d", out_count),
					exp_out[out_count], output_bus);
			end
			out_count++;
		end
	end

	always @(posedge clk) begin
		if (!rst && in_dev_ack) begin
			ack_count++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			errors++;
			$display("Timeout: the run was still going after %0d cycles", cycles);
			finish_run();
		end
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin : main
		int a;
		int i;
		acc_pkg::data_t k;
		rst = 1'b1;
		run = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		in_dev_hs = 1'b0;
		input_bus = '0;
		out_dev_hs = 1'b1;
		out_dev_ack = 1'b0;
		errors = 0;
		checks = 0;
		cycles = 0;
		in_next = 0;
		out_count = 0;
		ack_count = 0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		// Unused words halt with the address as operand
		for (a = 0; a < 256; a++) begin
			prog_mem[a] = {acc_pkg::OP_HALT, 8'(a)};
			write_word(8'(a), prog_mem[a]);
		end

		// Arithmetic and logic chain
		prog_len = 0;
		emit(acc_pkg::OP_LDI, rand_byte());
		emit(acc_pkg::OP_OUT, 0);
		emit(acc_pkg::OP_ADDI, rand_byte());
		emit(acc_pkg::OP_OUT, 0);
		emit(acc_pkg::OP_SUBI, rand_byte());
		emit(acc_pkg::OP_OUT, 0);
		emit(acc_pkg::OP_ANDI, rand_byte());
		emit(acc_pkg::OP_OUT, 0);
		emit(acc_pkg::OP_ORI, rand_byte());
		emit(acc_pkg::OP_OUT, 0);
		emit(acc_pkg::OP_XORI, rand_byte());
		emit(acc_pkg::OP_OUT, 0);
		emit(acc_pkg::OP_HALT, 0);
		run_test("arith_logic");

		// Shift chain where the first JC falls through and the second jumps to 15
		prog_len = 0;
		emit(acc_pkg::OP_LDI, 8'h96);
		emit(acc_pkg::OP_SHL, 0);
		emit(acc_pkg::OP_OUT, 0);
		emit(acc_pkg::OP_SHR, 0);
		emit(acc_pkg::OP_OUT, 0);
		emit(acc_pkg::OP_JC, 13);
		emit(acc_pkg::OP_SHR, 0);
		emit(acc_pkg::OP_SHR, 0);
		emit(acc_pkg::OP_OUT, 0);
		emit(acc_pkg::OP_JC, 15);
		emit(acc_pkg::OP_LDI, 8'hee);
		emit(acc_pkg::OP_OUT, 0);
		emit(acc_pkg::OP_HALT, 0);
		emit(acc_pkg::OP_LDI, 8'hdd);
		emit(acc_pkg::OP_OUT, 0);
		emit(acc_pkg::OP_LDI, 8'hcc);
		emit(acc_pkg::OP_OUT, 0);
		emit(acc_pkg::OP_HALT, 0);
		run_test("shift_carry");

		// Count down from a random N to 1
		prog_len = 0;
		k = (rand_byte() & 8'h0f) + 8'd1;
		emit(acc_pkg::OP_LDI, k);
		emit(acc_pkg::OP_OUT, 0);
		emit(acc_pkg::OP_SUBI, 1);
		emit(acc_pkg::OP_JZ, 5);
		emit(acc_pkg::OP_JMP, 1);
		emit(acc_pkg::OP_HALT, 0);
		run_test("loop");

		// Three nested subroutines with level i at 4 + 6 * (i - 1)
		prog_len = 0;
		emit(acc_pkg::OP_CALL, 4);
		emit(acc_pkg::OP_LDI, 8'h7e);
		emit(acc_pkg::OP_OUT, 0);
		emit(acc_pkg::OP_HALT, 0);
		for (i = 1; i <= 3; i++) begin
			emit(acc_pkg::OP_LDI, i);
			emit(acc_pkg::OP_OUT, 0);
			if (i < 3) begin
				emit(acc_pkg::OP_CALL, 4 + 6 * i);
				emit(acc_pkg::OP_LDI, 8'h10 + i);
				emit(acc_pkg::OP_OUT, 0);
			end
			emit(acc_pkg::OP_RET, 0);
		end
		run_test("calls_nested");

		// Endless recursion until the fifth CALL overflows the stack
		prog_len = 0;
		emit(acc_pkg::OP_LDI, 0);
		emit(acc_pkg::OP_ADDI, 1);
		emit(acc_pkg::OP_OUT, 0);
		emit(acc_pkg::OP_CALL, 1);
		run_test("calls_overflow");

		// IN, add constant, OUT
		prog_len = 0;
		k = rand_byte();
		in_bytes.delete();
		for (i = 0; i < 4; i++) begin
			in_bytes.push_back(rand_byte());
			emit(acc_pkg::OP_IN, 0);
			emit(acc_pkg::OP_ADDI, k);
			emit(acc_pkg::OP_OUT, 0);
		end
		emit(acc_pkg::OP_HALT, 0);
		run_test("input_hs");
		check_value("in_dev_ack pulses", in_bytes.size(), ack_count);
		in_bytes.delete();

		// Halted state holds with run still high
		prog_len = 0;
		emit(acc_pkg::OP_LDI, 8'h5a);
		emit(acc_pkg::OP_OUT, 0);
		emit(acc_pkg::OP_HALT, 0);
		run_test("halt");
		run = 1'b1;
		repeat (50) begin
			@(negedge clk);
			check_value("halted held", 1, halted);
			check_value("out_dev_req low", 0, out_dev_req);
		end
		run = 1'b0;

		finish_run();
	end

endmodule

// ==== vlog.f ====
hw/acc_pkg.sv
hw/acc_ifs.sv
hw/acc_control.sv
hw/acc_alu.sv
hw/pc_unit.sv
hw/instr_rom.sv
hw/io_port.sv
hw/acc_processor.sv
bench/acc_processor_props.sv
bench/acc_processor_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the accumulator processor testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module acc_processor_tb -Mdir obj_dir -o acc_processor_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/acc_processor_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
	exit 0
fi
exit 1
